// ==== source/lz_tile_cfg.svh ====
// --------------------
// lz tile configuration: word width, history depth and match floor.
// --------------------

`ifndef LZ_TILE_CFG_SVH
`define LZ_TILE_CFG_SVH

// bytes taken in per accepted word.
`define LZ_IN_BYTES 4

// history depth in bytes, which is also the largest offset searched.
// It must stay a multiple of LZ_IN_BYTES.
`define LZ_HIST_BYTES 16

// shortest match length that is reported.
`define LZ_MIN_MATCH 3

`endif

// ==== source/lz_data_pkg.sv ====
// --------------------
// lz data types: stream bytes, input words and the history window.
// --------------------

`default_nettype none

`include "lz_tile_cfg.svh"

package lz_data_pkg;

   typedef logic [7:0] byte_t;

   // byte 0 is the earliest byte of the word in the stream.
   typedef byte_t [`LZ_IN_BYTES-1:0] word_t;
   typedef logic [`LZ_IN_BYTES-1:0] word_vld_t;

   // index 0 is the byte just before the current word, index k-1 lies k bytes back.
   typedef byte_t [`LZ_HIST_BYTES-1:0] hist_t;
   typedef logic [`LZ_HIST_BYTES-1:0] hist_vld_t;

endpackage

`default_nettype wire

// ==== source/lz_match_pkg.sv ====
// --------------------
// lz match types: match lengths and offsets.
// --------------------

`default_nettype none

`include "lz_tile_cfg.svh"

package lz_match_pkg;

   // a length counts 0 up to a whole word.
   localparam int LEN_W = $clog2(`LZ_IN_BYTES + 1);

   // an offset runs from 1 to the history depth, 0 means no match.
   localparam int OFF_W = $clog2(`LZ_HIST_BYTES + 1);

   typedef logic [LEN_W-1:0] match_len_t;

   typedef logic [OFF_W-1:0] offset_t;

   // entry d-1 holds the length found at offset d.
   typedef match_len_t [`LZ_HIST_BYTES-1:0] len_vec_t;

endpackage

`default_nettype wire

// ==== source/lz_history_window.sv ====
// --------------------
// lz history window: holds the current word and shifts older bytes
// through the history, evicting the oldest on the shift-out port.
// --------------------

`timescale 1ns/1ps
`default_nettype none

`include "lz_tile_cfg.svh"

module lz_history_window (
   input  wire                      clk,
   input  wire                      rst_n,
   input  wire lz_data_pkg::word_t  in_data,
   input  wire                      in_vld,
   input  wire                      clr,
   output lz_data_pkg::word_t       cur_word,
   output logic                     cur_vld,
   output lz_data_pkg::hist_t       window,
   output lz_data_pkg::hist_vld_t   window_vld,
   output lz_data_pkg::word_t       hist_out,
   output lz_data_pkg::word_vld_t   hist_out_vld
);

   import lz_data_pkg::*;

   localparam int IN_BYTES = `LZ_IN_BYTES;
   localparam int HIST_BYTES = `LZ_HIST_BYTES;

   logic have_word;
   hist_t win_next;
   hist_vld_t win_vld_next;
   word_t evict;
   word_vld_t evict_vld;

   // the held word enters at index 0 with its latest byte first, older bytes move up.
   always_comb begin
      for (int k = 0; k < IN_BYTES; k++) begin
         win_next[k] = cur_word[IN_BYTES-1-k];
         win_vld_next[k] = have_word;
         evict[k] = window[HIST_BYTES-1-k];
         evict_vld[k] = window_vld[HIST_BYTES-1-k];
      end
      for (int k = IN_BYTES; k < HIST_BYTES; k++) begin
         win_next[k] = window[k-IN_BYTES];
         win_vld_next[k] = window_vld[k-IN_BYTES];
      end
   end

   always_ff @(posedge clk) begin
      if (in_vld) begin
         cur_word <= in_data;
         window <= win_next;
         hist_out <= evict;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         cur_vld <= 1'b0;
         have_word <= 1'b0;
         window_vld <= '0;
         hist_out_vld <= '0;
      end else begin
         cur_vld <= in_vld;
         hist_out_vld <= '0;
         if (clr) begin
            // a clear discards the history, so nothing valid leaves on this edge.
            window_vld <= '0;
            have_word <= in_vld;
         end else if (in_vld) begin
            window_vld <= win_vld_next;
            hist_out_vld <= evict_vld;
            have_word <= 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// ==== source/lz_offset_cell.sv ====
// --------------------
// lz offset cell: leading match length of the word at one offset.
// --------------------

`timescale 1ns/1ps
`default_nettype none

`include "lz_tile_cfg.svh"

module lz_offset_cell #(
   parameter int OFFSET = 1
) (
   input  wire lz_data_pkg::word_t      cur_word,
   input  wire lz_data_pkg::hist_t      window,
   input  wire lz_data_pkg::hist_vld_t  window_vld,
   output lz_match_pkg::match_len_t     match_len
);

   import lz_data_pkg::*;
   import lz_match_pkg::*;

   localparam int IN_BYTES = `LZ_IN_BYTES;

   byte_t cand;
   logic cand_vld;
   logic run;
   match_len_t len;

   // positions past the offset compare against the word's own earlier bytes.
   always_comb begin
      run = 1'b1;
      len = '0;
      for (int j = 0; j < IN_BYTES; j++) begin
         if (j < OFFSET) begin
            cand = window[OFFSET-1-j];
            cand_vld = window_vld[OFFSET-1-j];
         end else begin
            cand = cur_word[j-OFFSET];
            cand_vld = 1'b1;
         end
         run = run & cand_vld & (cand == cur_word[j]);
         if (run) begin
            len = len + 1'b1;
         end
      end
   end

   assign match_len = len;

endmodule

`default_nettype wire

// ==== source/lz_best_match.sv ====
// --------------------
// lz best match: picks the longest match over all offsets and
// registers it with the result valid.
// --------------------

`timescale 1ns/1ps
`default_nettype none

`include "lz_tile_cfg.svh"

module lz_best_match (
   input  wire                           clk,
   input  wire                           rst_n,
   input  wire lz_match_pkg::len_vec_t   lens,
   input  wire                           cur_vld,
   output logic                          res_vld,
   output lz_match_pkg::match_len_t      res_len,
   output lz_match_pkg::offset_t         res_offset
);

   import lz_match_pkg::*;

   localparam int HIST_BYTES = `LZ_HIST_BYTES;
   localparam match_len_t MIN_LEN = match_len_t'(`LZ_MIN_MATCH);

   match_len_t best_len;
   offset_t best_off;
   match_len_t sel_len;
   offset_t sel_off;

   // scanning from the far end lets a nearer offset take over on an equal length.
   always_comb begin
      best_len = '0;
      best_off = '0;
      for (int d = HIST_BYTES; d >= 1; d--) begin
         if (lens[d-1] >= best_len) begin
            best_len = lens[d-1];
            best_off = offset_t'(d);
         end
      end
   end

   // short matches are not worth coding and report as no match.
   always_comb begin
      if (best_len < MIN_LEN) begin
         sel_len = '0;
         sel_off = '0;
      end else begin
         sel_len = best_len;
         sel_off = best_off;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         res_vld <= 1'b0;
         res_len <= '0;
         res_offset <= '0;
      end else begin
         res_vld <= cur_vld;
         if (cur_vld) begin
            res_len <= sel_len;
            res_offset <= sel_off;
         end
      end
   end

endmodule

`default_nettype wire

// ==== source/lz_match_tile.sv ====
// --------------------
// lz match tile: history window, offset cells and best-match selector.
// --------------------

`timescale 1ns/1ps
`default_nettype none

`include "lz_tile_cfg.svh"

module lz_match_tile (
   input  wire                            clk,
   input  wire                            rst_n,
   input  wire lz_data_pkg::word_t        in_data,
   input  wire                            in_vld,
   input  wire                            clr,
   output wire                            res_vld,
   output wire lz_match_pkg::match_len_t  res_len,
   output wire lz_match_pkg::offset_t     res_offset,
   output wire lz_data_pkg::word_t        hist_out,
   output wire lz_data_pkg::word_vld_t    hist_out_vld
);

   import lz_data_pkg::*;
   import lz_match_pkg::*;

   word_t cur_word;
   logic cur_vld;
   hist_t window;
   hist_vld_t window_vld;
   len_vec_t lens;

   lz_history_window lz_history_window_inst (
      .clk          (clk),
      .rst_n        (rst_n),
      .in_data      (in_data),
      .in_vld       (in_vld),
      .clr          (clr),
      .cur_word     (cur_word),
      .cur_vld      (cur_vld),
      .window       (window),
      .window_vld   (window_vld),
      .hist_out     (hist_out),
      .hist_out_vld (hist_out_vld)
   );

   // one cell per offset, entry d-1 of the length bus belongs to offset d.
   for (genvar d = 1; d <= `LZ_HIST_BYTES; d++) begin : gen_offset
      lz_offset_cell #(
         .OFFSET (d)
      ) lz_offset_cell_inst (
         .cur_word   (cur_word),
         .window     (window),
         .window_vld (window_vld),
         .match_len  (lens[d-1])
      );
   end

   lz_best_match lz_best_match_inst (
      .clk        (clk),
      .rst_n      (rst_n),
      .lens       (lens),
      .cur_vld    (cur_vld),
      .res_vld    (res_vld),
      .res_len    (res_len),
      .res_offset (res_offset)
   );

endmodule

`default_nettype wire

// ==== verification/lz_tile_clk_gen.sv ====
// --------------------
// lz tile clock and reset generator for the testbench.
// --------------------

`timescale 1ns/1ps
`default_nettype none

module lz_tile_clk_gen #(
   parameter int PERIOD = 100,
   parameter int RESET_CYCLES = 8
) (
   output logic clk,
   output logic rst_n
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

   // reset is released on a falling edge, away from the sampling edge.
   initial begin
      rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
   end

endmodule

`default_nettype wire

// ==== verification/lz_tile_assert.sv ====
// --------------------
// lz tile checker: result valid timing and the match length floor.
// --------------------

`timescale 1ns/1ps
`default_nettype none

`include "lz_tile_cfg.svh"

module lz_tile_assert (
   input wire                           clk,
   input wire                           rst_n,
   input wire                           cur_vld,
   input wire                           res_vld,
   input wire lz_match_pkg::match_len_t res_len,
   input wire lz_match_pkg::offset_t    res_offset
);

   import lz_match_pkg::*;

   localparam match_len_t MIN_LEN = match_len_t'(`LZ_MIN_MATCH);

   int fail_count = 0;

   // every searched word gives a result on the next edge, and nothing else does.
   a_vld_follow : assert property (@(posedge clk) disable iff (!rst_n)
      res_vld == $past(cur_vld))
      else begin
         fail_count++;
         $error("res_vld does not follow cur_vld by one cycle");
      end

   a_len_floor : assert property (@(posedge clk) disable iff (!rst_n)
      (res_len == '0) || (res_len >= MIN_LEN))
      else begin
         fail_count++;
         $error("res_len is nonzero but below the minimum match");
      end

   a_offset_zero : assert property (@(posedge clk) disable iff (!rst_n)
      (res_offset == '0) == (res_len == '0))
      else begin
         fail_count++;
         $error("res_offset and res_len disagree on a missing match");
      end

endmodule

bind lz_match_tile lz_tile_assert lz_tile_assert_inst (
   .clk        (clk),
   .rst_n      (rst_n),
   .cur_vld    (cur_vld),
   .res_vld    (res_vld),
   .res_len    (res_len),
   .res_offset (res_offset)
);

`default_nettype wire

// ==== verification/lz_tile_tb.sv ====
// --------------------
// lz match tile testbench that checks a table of words against a byte stream model.
// --------------------

`timescale 1ns/1ps
`default_nettype none

`include "lz_tile_cfg.svh"

module lz_tile_tb;

   import lz_data_pkg::*;
   import lz_match_pkg::*;

   localparam int IN_BYTES = `LZ_IN_BYTES;
   localparam int HIST_BYTES = `LZ_HIST_BYTES;
   localparam int MIN_MATCH = `LZ_MIN_MATCH;

   logic clk;
   logic rst_n;
   word_t in_data;
   logic in_vld;
   logic clr;
   logic res_vld;
   match_len_t res_len;
   offset_t res_offset;
   word_t hist_out;
   word_vld_t hist_out_vld;

   // the table holds the stimulus columns and then the expected columns from the model.
   word_t row_data[$];
   logic row_vld[$];
   logic row_clr[$];
   match_len_t row_len[$];
   offset_t row_off[$];
   word_t row_hout[$];
   word_vld_t row_hvld[$];

   // the model keeps every byte accepted since the last clear, oldest first.
   byte_t stream_q[$];
   logic table_ready = 1'b0;

   lz_tile_clk_gen lz_tile_clk_gen_inst (
      .clk   (clk),
      .rst_n (rst_n)
   );

   lz_match_tile lz_match_tile_inst (
      .clk          (clk),
      .rst_n        (rst_n),
      .in_data      (in_data),
      .in_vld       (in_vld),
      .clr          (clr),
      .res_vld      (res_vld),
      .res_len      (res_len),
      .res_offset   (res_offset),
      .hist_out     (hist_out),
      .hist_out_vld (hist_out_vld)
   );

   task automatic abort_run();
      $display("RESULT: FAIL");
      $fatal(1, "simulation stopped on error");
   endtask

   task automatic check_value(string name, logic [31:0] actual, logic [31:0] expected);
      if (actual !== expected) begin
         $display("FAIL time=%0t signal=%s expected=%0h actual=%0h",
                  $time, name, expected, actual);
         abort_run();
      end
   endtask

   function automatic word_t pack_bytes(byte_t b0, byte_t b1, byte_t b2, byte_t b3);
      word_t w;
      w[0] = b0;
      w[1] = b1;
      w[2] = b2;
      w[3] = b3;
      return w;
   endfunction

   // longest leading match against the stream, smallest offset first.
   function automatic void find_best(output match_len_t len, output offset_t off);
      int base;
      int n;
      int best_n;
      int best_d;
      base = stream_q.size() - IN_BYTES;
      best_n = 0;
      best_d = 0;
      for (int d = 1; d <= HIST_BYTES; d++) begin
         n = 0;
         while (n < IN_BYTES && base + n - d >= 0 &&
                stream_q[base + n - d] == stream_q[base + n]) begin
            n++;
         end
         if (n > best_n) begin
            best_n = n;
            best_d = d;
         end
      end
      if (best_n < MIN_MATCH) begin
         best_n = 0;
         best_d = 0;
      end
      len = match_len_t'(best_n);
      off = offset_t'(best_d);
   endfunction

   task automatic add_row(word_t data, logic vld, logic clear);
      word_t hout;
      word_vld_t hvld;
      match_len_t len;
      offset_t off;
      hout = '0;
      hvld = '0;
      len = '0;
      off = '0;
      if (clear) begin
         stream_q.delete();
      end
      if (vld) begin
         for (int j = 0; j < IN_BYTES; j++) begin
            stream_q.push_back(data[j]);
         end
         // the window and the current word together hold the newest bytes.
         if (stream_q.size() > IN_BYTES + HIST_BYTES) begin
            for (int j = 0; j < IN_BYTES; j++) begin
               hout[j] = stream_q.pop_front();
            end
            hvld = '1;
         end
         find_best(len, off);
      end
      row_data.push_back(data);
      row_vld.push_back(vld);
      row_clr.push_back(clear);
      row_len.push_back(len);
      row_off.push_back(off);
      row_hout.push_back(hout);
      row_hvld.push_back(hvld);
   endtask

   task automatic build_table();
      int seed;
      word_t w;
      word_t p;
      logic vld;
      seed = 32'h33e2;
      // distinct words after reset; the sixth word pushes the first one out.
      for (int k = 0; k < 6; k++) begin
         w = pack_bytes(8'h10 * (k + 1), 8'h10 * (k + 1) + 1, 8'h10 * (k + 1) + 2,
                        8'h10 * (k + 1) + 3);
         add_row(w, 1'b1, 1'b0);
      end
      // exact repeats at offset 8, then nearer copies of the same word.
      w = pack_bytes(8'h70, 8'h71, 8'h72, 8'h73);
      p = pack_bytes(8'h80, 8'h81, 8'h82, 8'h83);
      add_row(w, 1'b1, 1'b0);
      add_row(p, 1'b1, 1'b0);
      add_row(w, 1'b1, 1'b0);
      add_row(p, 1'b1, 1'b0);
      add_row(w, 1'b1, 1'b0);
      add_row(w, 1'b1, 1'b0);
      // the first run of one byte has only a single matching history byte.
      add_row(pack_bytes(8'h01, 8'h02, 8'h03, 8'h07), 1'b1, 1'b1);
      add_row(pack_bytes(8'h07, 8'h07, 8'h07, 8'h07), 1'b1, 1'b0);
      add_row(pack_bytes(8'h05, 8'h05, 8'h05, 8'h05), 1'b1, 1'b0);
      add_row(pack_bytes(8'h05, 8'h05, 8'h05, 8'h05), 1'b1, 1'b0);
      // a two byte prefix is dropped, three bytes are reported.
      add_row(pack_bytes(8'ha1, 8'ha2, 8'hb3, 8'hb4), 1'b1, 1'b0);
      add_row(pack_bytes(8'ha1, 8'ha2, 8'hc5, 8'hc6), 1'b1, 1'b0);
      add_row(pack_bytes(8'ha1, 8'ha2, 8'hc5, 8'hd7), 1'b1, 1'b0);
      // idle gaps keep the history, a clear throws it away.
      p = pack_bytes(8'he0, 8'he1, 8'he2, 8'he3);
      add_row(p, 1'b1, 1'b0);
      add_row('0, 1'b0, 1'b0);
      add_row('0, 1'b0, 1'b0);
      add_row(p, 1'b1, 1'b0);
      add_row('0, 1'b0, 1'b1);
      add_row(p, 1'b1, 1'b0);
      add_row(pack_bytes(8'hf0, 8'hf1, 8'hf2, 8'hf3), 1'b1, 1'b1);
      add_row(p, 1'b1, 1'b0);
      for (int k = 0; k < 6; k++) begin
         w = pack_bytes(8'h40 + 4 * k, 8'h41 + 4 * k, 8'h42 + 4 * k, 8'h43 + 4 * k);
         add_row(w, 1'b1, 1'b0);
      end
      // random words over a four letter alphabet with a few idle cycles.
      for (int r = 0; r < 48; r++) begin
         for (int j = 0; j < IN_BYTES; j++) begin
            w[j] = 8'h61 + 8'($random(seed) & 3);
         end
         vld = (($random(seed) & 7) != 0);
         add_row(w, vld, 1'b0);
      end
   endtask

   task automatic check_shift_out(int k);
      check_value("hist_out_vld", 32'(hist_out_vld), 32'(row_hvld[k]));
      if (row_hvld[k] != '0) begin
         check_value("hist_out", 32'(hist_out), 32'(row_hout[k]));
      end
   endtask

   task automatic check_result(int k);
      check_value("res_vld", 32'(res_vld), 32'(row_vld[k]));
      if (row_vld[k]) begin
         check_value("res_len", 32'(res_len), 32'(row_len[k]));
         check_value("res_offset", 32'(res_offset), 32'(row_off[k]));
      end
   endtask

   initial begin : run_table
      int n;
      in_data = '0;
      in_vld = 1'b0;
      clr = 1'b0;
      $timeformat(-9, 0, " ns", 0);
      build_table();
      n = row_vld.size();
      table_ready = 1'b1;
      wait (rst_n === 1'b1);
      // row i is driven on a falling edge and its result is read two falling edges later.
      for (int i = 0; i < n + 2; i++) begin
         @(negedge clk);
         if (i >= 1 && i <= n) begin
            check_shift_out(i - 1);
         end
         if (i >= 2) begin
            check_result(i - 2);
         end
         if (i < n) begin
            in_data = row_data[i];
            in_vld = row_vld[i];
            clr = row_clr[i];
         end else begin
            in_data = '0;
            in_vld = 1'b0;
            clr = 1'b0;
         end
      end
      if (lz_match_tile_inst.lz_tile_assert_inst.fail_count == 0) begin
         $display("RESULT: PASS");
         $finish;
      end else begin
         $display("ERROR: a concurrent assertion on the DUT failed during the run");
         abort_run();
      end
   end

   initial begin : assertion_watch
      wait (lz_match_tile_inst.lz_tile_assert_inst.fail_count != 0);
      $display("ERROR: a concurrent assertion on the DUT failed");
      abort_run();
   end

   initial begin : watchdog
      wait (table_ready);
      #((row_vld.size() + 20) * 100);
      $display("ERROR: watchdog expired, the run hung before the table finished");
      abort_run();
   end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+source
source/lz_data_pkg.sv
source/lz_match_pkg.sv
source/lz_history_window.sv
source/lz_offset_cell.sv
source/lz_best_match.sv
source/lz_match_tile.sv
verification/lz_tile_clk_gen.sv
verification/lz_tile_assert.sv
verification/lz_tile_tb.sv
